//--- hdl/csr_addr_pkg.sv
package csr_addr_pkg;

    typedef logic [11:0] csr_addr_t;

    // Machine trap setup and handling.
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;

    // Machine counters.
    localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH = 12'hB82;

    // User read-only aliases.
    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_TIME      = 12'hC01;
    localparam csr_addr_t CSR_INSTRET   = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH    = 12'hC80;
    localparam csr_addr_t CSR_TIMEH     = 12'hC81;
    localparam csr_addr_t CSR_INSTRETH  = 12'hC82;

    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b00,
        CSR_OP_SET   = 2'b01,
        CSR_OP_CLEAR = 2'b10
    } csr_op_t;

    typedef enum logic {
        CSR_SRC_IMM = 1'b0,
        CSR_SRC_REG = 1'b1
    } csr_src_t;

    localparam logic [1:0] PRIV_MACHINE = 2'b11;

    // MXL = 1 for 32 bits, extension I only.
    localparam logic [31:0] MISA_RV32I = {
        2'b01,
        4'b0000,
        26'b00_0000_0000_0000_0001_0000_0000
    };

endpackage

//--- hdl/csr_types_pkg.sv
package csr_types_pkg;

    import csr_addr_pkg::*;

    typedef logic [31:0] csr_word_t;
    typedef logic [63:0] counter_t;

    typedef struct packed {
        logic      write;
        csr_op_t   op;
        csr_src_t  src;
        csr_addr_t addr;
        csr_word_t rs1;
        csr_word_t imm;
    } csr_request_t;

    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;         // Bit 7.
        logic [2:0]  rsvd_6_4;
        logic        mie;          // Bit 3.
        logic [2:0]  rsvd_2_0;
    } mstatus_fields_t;

    typedef struct packed {
        logic [19:0] rsvd_31_12;
        logic        meie;
        logic [2:0]  rsvd_10_8;
        logic        mtie;
        logic [2:0]  rsvd_6_4;
        logic        msie;
        logic [2:0]  rsvd_2_0;
    } mie_fields_t;

    typedef struct packed {
        logic [29:0] base;
        logic        rsvd_1;
        logic        mode;         // 0 direct, 1 vectored.
    } mtvec_fields_t;

    typedef struct packed {
        logic        interrupt;
        logic [26:0] rsvd_30_4;
        logic [3:0]  code;
    } mcause_fields_t;

    // New CSR value, seen through the layout of the selected target.
    typedef union packed {
        csr_word_t       word;
        mstatus_fields_t mstatus;
        mie_fields_t     mie;
        mtvec_fields_t   mtvec;
        mcause_fields_t  mcause;
    } csr_write_word_u;

    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mtvec;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
    } csr_write_sel_t;

    typedef struct packed {
        logic        mstatus_mpie;
        logic        mstatus_mie;
        logic        mie_meie;
        logic        mie_mtie;
        logic        mie_msie;
        logic [29:0] mtvec_base;
        logic        mtvec_mode;
        csr_word_t   mscratch;
        logic [29:0] mepc;         // Always word aligned.
        logic        mcause_interrupt;
        logic [3:0]  mcause_code;
        csr_word_t   mtval;
    } trap_state_t;

endpackage

//--- hdl/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux
    import csr_addr_pkg::*, csr_types_pkg::*;
#(
    parameter int          COUNTER_WIDTH = 64,
    parameter logic [31:0] MISA_VALUE    = MISA_RV32I
) (
    input  csr_addr_t      addr,
    input  trap_state_t    state,
    input  counter_t       cycle_count,
    input  counter_t       instret_count,
    output csr_word_t      read_value,
    output csr_write_sel_t write_sel
);

    mstatus_fields_t mstatus_rd;
    mie_fields_t     mie_rd;
    mtvec_fields_t   mtvec_rd;
    mcause_fields_t  mcause_rd;
    counter_t        cycle_val;
    counter_t        instret_val;

    // Only the implemented counter bits are visible.
    assign cycle_val   = counter_t'(cycle_count[COUNTER_WIDTH-1:0]);
    assign instret_val = counter_t'(instret_count[COUNTER_WIDTH-1:0]);

    always_comb begin
        mstatus_rd      = '0;
        mstatus_rd.mpp  = PRIV_MACHINE;  // Machine mode only.
        mstatus_rd.mpie = state.mstatus_mpie;
        mstatus_rd.mie  = state.mstatus_mie;

        mie_rd      = '0;
        mie_rd.meie = state.mie_meie;
        mie_rd.mtie = state.mie_mtie;
        mie_rd.msie = state.mie_msie;

        mtvec_rd      = '0;
        mtvec_rd.base = state.mtvec_base;
        mtvec_rd.mode = state.mtvec_mode;

        mcause_rd           = '0;
        mcause_rd.interrupt = state.mcause_interrupt;
        mcause_rd.code      = state.mcause_code;
    end

    always_comb begin
        read_value = '0;
        write_sel  = '0;
        case (addr)
            CSR_MSTATUS: begin
                read_value        = mstatus_rd;
                write_sel.mstatus = 1'b1;
            end
            CSR_MISA:     read_value = MISA_VALUE;
            CSR_MIE: begin
                read_value    = mie_rd;
                write_sel.mie = 1'b1;
            end
            CSR_MTVEC: begin
                read_value      = mtvec_rd;
                write_sel.mtvec = 1'b1;
            end
            CSR_MSCRATCH: begin
                read_value         = state.mscratch;
                write_sel.mscratch = 1'b1;
            end
            CSR_MEPC: begin
                read_value     = {state.mepc, 2'b00};
                write_sel.mepc = 1'b1;
            end
            CSR_MCAUSE: begin
                read_value       = mcause_rd;
                write_sel.mcause = 1'b1;
            end
            CSR_MTVAL: begin
                read_value      = state.mtval;
                write_sel.mtval = 1'b1;
            end
            CSR_MCYCLE, CSR_CYCLE, CSR_TIME:       read_value = cycle_val[31:0];
            CSR_MCYCLEH, CSR_CYCLEH, CSR_TIMEH:    read_value = cycle_val[63:32];
            CSR_MINSTRET, CSR_INSTRET:             read_value = instret_val[31:0];
            CSR_MINSTRETH, CSR_INSTRETH:           read_value = instret_val[63:32];
            default:      read_value = '0;      // mip, pmp, hpm, ids, unknown.
        endcase
    end

endmodule

//--- hdl/machine_trap_csrs.sv
`timescale 1ns/1ps

module machine_trap_csrs
    import csr_addr_pkg::*, csr_types_pkg::*;
(
    input  logic           clk,
    input  logic           reset_,
    input  logic           stall,
    input  csr_request_t   req,
    input  csr_write_sel_t write_sel,
    input  csr_word_t      old_value,
    output trap_state_t    state
);

    csr_word_t       operand;
    csr_write_word_u new_value;
    logic            write_en;

    assign operand  = (req.src == CSR_SRC_REG) ? req.rs1 : req.imm;
    assign write_en = req.write && !stall;

    // Read-modify-write against the current read word.
    always_comb begin
        case (req.op)
            CSR_OP_WRITE: new_value.word = operand;
            CSR_OP_SET:   new_value.word = old_value | operand;
            CSR_OP_CLEAR: new_value.word = old_value & ~operand;
            default:      new_value.word = old_value;  // Unused op keeps value.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            state <= '0;
        end else if (write_en) begin
            if (write_sel.mstatus) begin
                state.mstatus_mpie <= new_value.mstatus.mpie;
                state.mstatus_mie  <= new_value.mstatus.mie;
            end
            if (write_sel.mie) begin
                state.mie_meie <= new_value.mie.meie;
                state.mie_mtie <= new_value.mie.mtie;
                state.mie_msie <= new_value.mie.msie;
            end
            if (write_sel.mtvec) begin
                state.mtvec_base <= new_value.mtvec.base;
                state.mtvec_mode <= new_value.mtvec.mode;
            end
            if (write_sel.mscratch) begin
                state.mscratch <= new_value.word;
            end
            if (write_sel.mepc) begin
                state.mepc <= new_value.word[31:2];  // Low bits dropped.
            end
            if (write_sel.mcause) begin
                state.mcause_interrupt <= new_value.mcause.interrupt;
                state.mcause_code      <= new_value.mcause.code;
            end
            if (write_sel.mtval) begin
                state.mtval <= new_value.word;
            end
        end
    end

endmodule

//--- hdl/csr_counters.sv
`timescale 1ns/1ps

module csr_counters
    import csr_types_pkg::*;
#(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic     clk,
    input  logic     reset_,
    input  logic     instr_retired,
    output counter_t cycle_count,
    output counter_t instret_count
);

    logic [COUNTER_WIDTH-1:0] cycle_q;
    logic [COUNTER_WIDTH-1:0] instret_q;

    // Counting continues through stalls.
    always_ff @(posedge clk) begin
        if (!reset_) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            cycle_q <= cycle_q + COUNTER_WIDTH'(1);
            if (instr_retired) begin
                instret_q <= instret_q + COUNTER_WIDTH'(1);
            end
        end
    end

    // Zero extended to the full 64 bits.
    assign cycle_count   = counter_t'(cycle_q);
    assign instret_count = counter_t'(instret_q);

endmodule

//--- hdl/rv32_csr_file.sv
`timescale 1ns/1ps

module rv32_csr_file
    import csr_addr_pkg::*, csr_types_pkg::*;
#(
    parameter int          COUNTER_WIDTH = 64,
    parameter logic [31:0] MISA_VALUE    = MISA_RV32I
) (
    input  logic         clk,
    input  logic         reset_,
    input  logic         stall,
    input  csr_request_t req,
    input  logic         instr_retired,
    output csr_word_t    read_value,
    output counter_t     cycle
);

    trap_state_t    state;
    csr_write_sel_t write_sel;
    counter_t       instret_count;

    csr_read_mux #(
        .COUNTER_WIDTH (COUNTER_WIDTH),
        .MISA_VALUE    (MISA_VALUE)
    ) read_mux (
        .addr          (req.addr),
        .state         (state),
        .cycle_count   (cycle),
        .instret_count (instret_count),
        .read_value    (read_value),
        .write_sel     (write_sel)
    );

    // Old value for set and clear is the current read word.
    machine_trap_csrs trap_csrs (
        .clk       (clk),
        .reset_    (reset_),
        .stall     (stall),
        .req       (req),
        .write_sel (write_sel),
        .old_value (read_value),
        .state     (state)
    );

    csr_counters #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) counters (
        .clk           (clk),
        .reset_        (reset_),
        .instr_retired (instr_retired),
        .cycle_count   (cycle),
        .instret_count (instret_count)
    );

endmodule

//--- verification/rv32_csr_file_sva.sv
`timescale 1ns/1ps

module rv32_csr_file_sva
    import csr_types_pkg::*;
#(
    parameter bit COUNTERS = 1'b0
) (
    input logic        clk,
    input logic        reset_,
    input logic        stall,
    input logic        instr_retired,
    input counter_t    cycle_count,
    input counter_t    instret_count,
    input trap_state_t state
);

    if (COUNTERS) begin : counter_rules
        cycle_steps: assert property (@(posedge clk)
            $past(reset_) |-> cycle_count == $past(cycle_count) + 64'd1)
            else $error("cycle count did not advance by one");

        instret_holds: assert property (@(posedge clk)
            $past(reset_) && !$past(instr_retired) |-> instret_count == $past(instret_count))
            else $error("instret changed without a retirement pulse");
    end else begin : trap_rules
        // Stalled edge must not load any register.
        stall_holds: assert property (@(posedge clk)
            $past(reset_) && $past(stall) |-> state == $past(state))
            else $error("trap register changed while stalled");
    end

endmodule

bind csr_counters rv32_csr_file_sva #(.COUNTERS(1'b1)) counters_sva (
    .clk           (clk),
    .reset_        (reset_),
    .stall         (1'b0),
    .instr_retired (instr_retired),
    .cycle_count   (cycle_count),
    .instret_count (instret_count),
    .state         ('0)
);

bind machine_trap_csrs rv32_csr_file_sva #(.COUNTERS(1'b0)) trap_sva (
    .clk           (clk),
    .reset_        (reset_),
    .stall         (stall),
    .instr_retired (1'b0),
    .cycle_count   ('0),
    .instret_count ('0),
    .state         (state)
);

//--- verification/rv32_csr_file_tb.sv
`timescale 1ns/1ps

module rv32_csr_file_tb
    import csr_addr_pkg::*, csr_types_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_OPS    = 60;
    localparam int STALL_OPS     = 10;
    localparam int GAP           = 7;
    localparam int RETIRE_CYCLES = 64;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 11 + 2 * RANDOM_OPS + 2 * STALL_OPS
                                 + (8 + GAP) + RETIRE_CYCLES + 25 + 1;

    localparam logic [31:0] MISA_EXPECTED = 32'h4000_1100;  // RV32 with I and M.
    localparam csr_word_t   MSTATUS_MASK  = 32'h0000_0088;  // MPIE and MIE.
    localparam csr_word_t   MSTATUS_MPP   = 32'h0000_1800;
    localparam csr_word_t   MIE_MASK      = 32'h0000_0888;  // MEIE, MTIE, MSIE.
    localparam csr_word_t   MTVEC_MASK    = 32'hFFFF_FFFD;
    localparam csr_word_t   MEPC_MASK     = 32'hFFFF_FFFC;
    localparam csr_word_t   MCAUSE_MASK   = 32'h8000_000F;

    logic         clk;
    logic         reset_;
    logic         stall;
    logic         instr_retired;
    csr_request_t req;
    csr_word_t    read_value;
    counter_t     cycle;

    // Reference model.
    csr_word_t m_mstatus;
    csr_word_t m_mie;
    csr_word_t m_mtvec;
    csr_word_t m_mscratch;
    csr_word_t m_mepc;
    csr_word_t m_mcause;
    csr_word_t m_mtval;
    counter_t  m_cycle;
    counter_t  m_instret;
    bit        model_valid;

    int          word_errors;
    int          count_errors;
    logic [15:0] lfsr_state;

    csr_addr_t writable_addrs [7] = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                                      CSR_MEPC, CSR_MCAUSE, CSR_MTVAL};
    csr_addr_t reset_addrs [4] = '{CSR_MISA, CSR_MCYCLE, CSR_MINSTRET, CSR_CYCLE};
    csr_addr_t retire_addrs [4] = '{CSR_MINSTRET, CSR_INSTRET, CSR_MINSTRETH,
                                    CSR_INSTRETH};
    // mip, hpm event and counter, pmp, ids, unknown.
    csr_addr_t zero_addrs [9] = '{12'h344, 12'h323, 12'hB03, 12'hC03, 12'h3A0,
                                  12'h3B0, 12'hF11, 12'hF12, 12'h7FF};

    rv32_csr_file #(
        .COUNTER_WIDTH (64),
        .MISA_VALUE    (MISA_EXPECTED)
    ) uut (
        .clk           (clk),
        .reset_        (reset_),
        .stall         (stall),
        .req           (req),
        .instr_retired (instr_retired),
        .read_value    (read_value),
        .cycle         (cycle)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1.
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic csr_word_t expected_read(csr_addr_t addr);
        case (addr)
            CSR_MSTATUS:                        return m_mstatus | MSTATUS_MPP;
            CSR_MISA:                           return MISA_EXPECTED;
            CSR_MIE:                            return m_mie;
            CSR_MTVEC:                          return m_mtvec;
            CSR_MSCRATCH:                       return m_mscratch;
            CSR_MEPC:                           return m_mepc;
            CSR_MCAUSE:                         return m_mcause;
            CSR_MTVAL:                          return m_mtval;
            CSR_MCYCLE, CSR_CYCLE, CSR_TIME:    return m_cycle[31:0];
            CSR_MCYCLEH, CSR_CYCLEH, CSR_TIMEH: return m_cycle[63:32];
            CSR_MINSTRET, CSR_INSTRET:          return m_instret[31:0];
            CSR_MINSTRETH, CSR_INSTRETH:        return m_instret[63:32];
            default:                            return '0;
        endcase
    endfunction

    function automatic void model_write(csr_addr_t addr, csr_word_t value);
        case (addr)
            CSR_MSTATUS:  m_mstatus  = value & MSTATUS_MASK;
            CSR_MIE:      m_mie      = value & MIE_MASK;
            CSR_MTVEC:    m_mtvec    = value & MTVEC_MASK;
            CSR_MSCRATCH: m_mscratch = value;
            CSR_MEPC:     m_mepc     = value & MEPC_MASK;
            CSR_MCAUSE:   m_mcause   = value & MCAUSE_MASK;
            CSR_MTVAL:    m_mtval    = value;
            default:      ;                                  // Read-only or absent.
        endcase
    endfunction

    task automatic check_word(csr_word_t actual, csr_word_t expected, string what);
        if (actual !== expected) begin
            word_errors++;
            $display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_count(counter_t actual, counter_t expected, string what);
        if (actual !== expected) begin
            count_errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    // Mid-cycle, inputs and outputs are stable.
    always @(negedge clk) begin : compare
        csr_word_t old_word;
        csr_word_t operand;
        csr_word_t new_word;
        if (model_valid) begin
            check_word(read_value, expected_read(req.addr),
                       $sformatf("read of CSR 0x%03h", req.addr));
            check_count(cycle, m_cycle, "cycle output");
        end
        if (!reset_) begin
            m_mstatus   = '0;
            m_mie       = '0;
            m_mtvec     = '0;
            m_mscratch  = '0;
            m_mepc      = '0;
            m_mcause    = '0;
            m_mtval     = '0;
            m_cycle     = '0;
            m_instret   = '0;
            model_valid = 1'b1;
        end else begin
            old_word = expected_read(req.addr);
            operand  = (req.src == CSR_SRC_REG) ? req.rs1 : req.imm;
            if (req.write && !stall) begin
                case (req.op)
                    CSR_OP_WRITE: new_word = operand;
                    CSR_OP_SET:   new_word = old_word | operand;
                    CSR_OP_CLEAR: new_word = old_word & ~operand;
                    default:      new_word = old_word;
                endcase
                model_write(req.addr, new_word);
            end
            m_cycle = m_cycle + 64'd1;
            if (instr_retired) begin
                m_instret = m_instret + 64'd1;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic do_read(csr_addr_t addr);
        req.write = 1'b0;
        req.addr  = addr;
        next_cycle();
    endtask

    task automatic do_write(csr_addr_t addr, logic stalled);
        logic [31:0] pick;
        req.write = 1'b1;
        req.addr  = addr;
        pick      = random_bits(2) % 32'd3;
        req.op    = csr_op_t'(pick[1:0]);
        pick      = random_bits(1);
        req.src   = csr_src_t'(pick[0]);
        req.rs1   = random_bits(32);
        req.imm   = random_bits(32);
        stall     = stalled;
        next_cycle();
        req.write = 1'b0;
        stall     = 1'b0;
    endtask

    task automatic read_against_cycle(csr_addr_t addr, bit high);
        req.write = 1'b0;
        req.addr  = addr;
        @(negedge clk);
        if (high) begin
            check_word(read_value, cycle[63:32], $sformatf("CSR 0x%03h vs cycle", addr));
        end else begin
            check_word(read_value, cycle[31:0], $sformatf("CSR 0x%03h vs cycle", addr));
        end
        next_cycle();
    endtask

    initial begin : stimulus
        logic [31:0] pick;
        csr_word_t   first_read;
        csr_word_t   second_read;
        lfsr_state    = 16'd81;
        word_errors   = 0;
        count_errors  = 0;
        model_valid   = 1'b0;
        reset_        = 1'b0;
        stall         = 1'b0;
        instr_retired = 1'b0;
        req           = '0;
        repeat (RESET_CYCLES) next_cycle();
        reset_ = 1'b1;

        foreach (writable_addrs[i]) do_read(writable_addrs[i]);
        foreach (reset_addrs[i]) do_read(reset_addrs[i]);

        repeat (RANDOM_OPS) begin
            pick = random_bits(3) % 32'd7;
            do_write(writable_addrs[pick[2:0]], 1'b0);
            do_read(writable_addrs[pick[2:0]]);
        end

        repeat (STALL_OPS) begin
            pick = random_bits(3) % 32'd7;
            do_write(writable_addrs[pick[2:0]], 1'b1);
            do_read(writable_addrs[pick[2:0]]);
        end

        read_against_cycle(CSR_MCYCLE, 1'b0);
        read_against_cycle(CSR_CYCLE, 1'b0);
        read_against_cycle(CSR_TIME, 1'b0);
        read_against_cycle(CSR_CYCLEH, 1'b1);
        read_against_cycle(CSR_TIMEH, 1'b1);
        read_against_cycle(CSR_MCYCLEH, 1'b1);
        req.addr = CSR_MCYCLE;
        @(negedge clk);
        first_read = read_value;
        repeat (GAP) @(negedge clk);
        second_read = read_value;
        check_word(second_read - first_read, csr_word_t'(GAP), "mcycle step over gap");
        next_cycle();

        for (int i = 0; i < RETIRE_CYCLES; i++) begin
            pick          = random_bits(1);
            instr_retired = pick[0];
            req.addr      = retire_addrs[i % 4];
            next_cycle();
        end
        instr_retired = 1'b0;

        foreach (zero_addrs[i]) begin
            do_write(zero_addrs[i], 1'b0);
            do_read(zero_addrs[i]);
        end
        foreach (writable_addrs[i]) do_read(writable_addrs[i]);

        next_cycle();
        $display("Errors: %0d read value, %0d cycle output", word_errors, count_errors);
        if (word_errors + count_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TOTAL_CYCLES * CLK_PERIOD + 400);
        $display("Timeout: tests still running after %0d ns",
                 TOTAL_CYCLES * CLK_PERIOD + 400);
        $display("Test failed");
        $finish;
    end

endmodule

//--- sources.f
hdl/csr_addr_pkg.sv
hdl/csr_types_pkg.sv
hdl/csr_read_mux.sv
hdl/machine_trap_csrs.sv
hdl/csr_counters.sv
hdl/rv32_csr_file.sv
verification/rv32_csr_file_sva.sv
verification/rv32_csr_file_tb.sv

//--- run.sh
#!/bin/sh
# Builds the CSR file testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module rv32_csr_file_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vrv32_csr_file_tb)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
else
    exit 1
fi
